// ==== bench/spi_host_tb.sv ====
module spi_host_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD  = 10;
	localparam int MAX_HALF    = 6;
	localparam int RAND_BURSTS = 12;
	// Bytes shifted over the whole run
	localparam int TOTAL_BYTES = RAND_BURSTS * 8 + 12 + 8;
	// Worst case 18 half periods per byte, plus room for resets, reads and the stall window
	localparam int WATCHDOG_NS = TOTAL_BYTES * 18 * (MAX_HALF + 1) * CLK_PERIOD + 100_000;
	// Longest wait for one received byte, in clk cycles
	localparam int RX_WAIT     = 20 * (MAX_HALF + 1) + 20;

	logic                         clk;
	logic                         arst_n;
	logic [spi_pkg::HALF_W-1:0]   half_period;
	logic                         tx_wr;
	logic [spi_pkg::BYTE_W-1:0]   tx_data;
	logic                         tx_full;
	logic                         go;
	logic                         busy;
	logic                         rx_rd;
	logic [spi_pkg::BYTE_W-1:0]   rx_data;
	logic                         rx_empty;
	logic                         spi_sck;
	logic                         spi_mosi;
	logic                         spi_miso = 1'b0;
	logic                         spi_cs_n;

	integer seed = 32'h4371_cd38;

	// Reference model, bytes written by the host and due on MOSI
	logic [spi_pkg::BYTE_W-1:0]   wr_q[$];
	// Bytes the slave saw on MOSI
	logic [spi_pkg::BYTE_W-1:0]   obs_q[$];
	// Response bytes the slave finished shifting out on MISO
	logic [spi_pkg::BYTE_W-1:0]   resp_q[$];

	string test_name;
	int    test_errs;
	int    tests_passed;
	int    tests_failed;
	int    frame_errs;
	int    frame_checks;

	spi_host_top i_spi_host_top (
		.clk         (clk),
		.arst_n      (arst_n),
		.half_period (half_period),
		.tx_wr       (tx_wr),
		.tx_data     (tx_data),
		.tx_full     (tx_full),
		.go          (go),
		.busy        (busy),
		.rx_rd       (rx_rd),
		.rx_data     (rx_data),
		.rx_empty    (rx_empty),
		.spi_sck     (spi_sck),
		.spi_mosi    (spi_mosi),
		.spi_miso    (spi_miso),
		.spi_cs_n    (spi_cs_n)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [spi_pkg::BYTE_W-1:0] rand_byte();
		int r;
		r = $random(seed);
		return r[spi_pkg::BYTE_W-1:0];
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed);
		return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
	endfunction

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		if (test_errs == 0)
			tests_passed++;
		else
			tests_failed++;
		$display("%-14s %s, %0d errors", test_name, (test_errs == 0) ? "pass" : "fail", test_errs);
	endtask

	task automatic check_value(input string what, input int exp, input int act);
		assert (exp == act) else begin
			$display("Error: %s %s expected %0h actual %0h", test_name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_flag(input bit ok, input string msg);
		assert (ok) else begin
			$display("%s: %s", test_name, msg);
			test_errs++;
		end
	endtask

	// accept comes from the caller's own model of the transmit queue
	task automatic write_byte(input logic [spi_pkg::BYTE_W-1:0] b, input bit accept);
		@(negedge clk);
		tx_wr   = 1'b1;
		tx_data = b;
		if (accept)
			wr_q.push_back(b);
		@(negedge clk);
		tx_wr = 1'b0;
	endtask

	task automatic pulse_go();
		@(negedge clk);
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
	endtask

	// End of burst is busy falling
	task automatic wait_idle();
		while (busy)
			@(negedge clk);
	endtask

	task automatic compare_tx();
		check_value("mosi byte count", wr_q.size(), obs_q.size());
		while (wr_q.size() > 0 && obs_q.size() > 0)
			check_value("mosi byte", wr_q.pop_front(), obs_q.pop_front());
		wr_q.delete();
		obs_q.delete();
	endtask

	// Pop n bytes from the receive queue, waiting for each with a bound
	task automatic drain_rx(input int n);
		int waited;
		for (int i = 0; i < n; i++) begin
			waited = 0;
			@(negedge clk);
			while (rx_empty && waited < RX_WAIT) begin
				@(negedge clk);
				waited++;
			end
			check_flag(!rx_empty, "receive queue stayed empty while a byte was due");
			check_flag(resp_q.size() > 0, "receive queue holds a byte the slave never sent");
			if (!rx_empty && resp_q.size() > 0)
				check_value("rx byte", resp_q.pop_front(), rx_data);
			rx_rd = 1'b1;
			@(negedge clk);
			rx_rd = 1'b0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// SPI slave, mode 0

	logic [spi_pkg::BYTE_W-1:0]   slv_resp;
	logic [spi_pkg::BYTE_W-1:0]   slv_shift;
	logic [spi_pkg::BYTE_W-1:0]   slv_in;
	int                           slv_bits;
	logic                         slv_cs_q  = 1'b1;
	logic                         slv_sck_q = 1'b0;

	always @(spi_sck or spi_cs_n) begin
		if (!spi_cs_n && slv_cs_q) begin
			// Chip select fell, bit 7 goes out before the first edge
			slv_resp  = rand_byte();
			slv_shift = slv_resp;
			slv_bits  = 0;
			spi_miso  = slv_shift[spi_pkg::BYTE_W-1];
		end else if (!spi_cs_n && spi_sck && !slv_sck_q) begin
			slv_in = {slv_in[spi_pkg::BYTE_W-2:0], spi_mosi};
			slv_bits++;
			if (slv_bits == spi_pkg::BYTE_W) begin
				obs_q.push_back(slv_in);
				resp_q.push_back(slv_resp);
			end
		end else if (!spi_cs_n && !spi_sck && slv_sck_q) begin
			// Next bit, or a fresh response byte after eight
			if (slv_bits == spi_pkg::BYTE_W) begin
				slv_resp  = rand_byte();
				slv_shift = slv_resp;
				slv_bits  = 0;
			end else begin
				slv_shift = {slv_shift[spi_pkg::BYTE_W-2:0], 1'b0};
			end
			spi_miso = slv_shift[spi_pkg::BYTE_W-1];
		end
		slv_cs_q  = spi_cs_n;
		slv_sck_q = spi_sck;
	end

	////////////////////////////////////////////////////////////////////////////
	// Chip select framing and SCK high time

	logic sck_q    = 1'b0;
	int   high_cnt = 0;

	always @(negedge clk) begin
		if (arst_n === 1'b1) begin
			assert (spi_cs_n || busy) else begin
				$display("framing: chip select low while busy is low");
				frame_errs++;
			end
			assert (!spi_cs_n || spi_sck == sck_q) else begin
				$display("framing: SCK toggled while chip select was high");
				frame_errs++;
			end
			if (spi_sck) begin
				high_cnt++;
			end else if (sck_q) begin
				frame_checks++;
				assert (high_cnt == half_period + 1) else begin
					$display("Error: framing sck high cycles expected %0d actual %0d",
						half_period + 1, high_cnt);
					frame_errs++;
				end
				high_cnt = 0;
			end
		end
		sck_q = spi_sck;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence

	initial begin
		int   n;
		int   hp;
		logic stalled;

		arst_n      = 1'b0;
		half_period = 8'd1;
		tx_wr       = 1'b0;
		tx_data     = '0;
		go          = 1'b0;
		rx_rd       = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		begin_test("reset");
		@(negedge clk);
		check_value("spi_cs_n", 1, spi_cs_n);
		check_value("spi_sck", 0, spi_sck);
		check_value("busy", 0, busy);
		check_value("tx_full", 0, tx_full);
		check_value("rx_empty", 1, rx_empty);
		end_test();

		begin_test("rand_bursts");
		for (int b = 0; b < RAND_BURSTS; b++) begin
			n  = rand_range(1, spi_pkg::FIFO_DEPTH);
			hp = rand_range(1, MAX_HALF);
			@(negedge clk);
			half_period = hp[spi_pkg::HALF_W-1:0];
			for (int i = 0; i < n; i++)
				write_byte(rand_byte(), 1'b1);
			pulse_go();
			check_flag(busy, "busy did not rise after go");
			wait_idle();
			compare_tx();
			drain_rx(n);
			check_value("unread responses", 0, resp_q.size());
			resp_q.delete();
		end
		end_test();

		begin_test("back_pressure");
		hp = rand_range(1, MAX_HALF);
		@(negedge clk);
		half_period = hp[spi_pkg::HALF_W-1:0];
		for (int i = 0; i < spi_pkg::FIFO_DEPTH; i++)
			write_byte(rand_byte(), 1'b1);
		pulse_go();
		// Four more bytes as the transmit queue frees up
		for (int i = 0; i < 4; i++) begin
			while (tx_full)
				@(negedge clk);
			write_byte(rand_byte(), 1'b1);
		end
		// A full receive queue plus one byte parked in the controller
		while (resp_q.size() < spi_pkg::FIFO_DEPTH + 1)
			@(negedge clk);
		repeat (4 * (hp + 1)) @(negedge clk);
		stalled = 1'b1;
		repeat (20 * (hp + 1)) begin
			@(negedge clk);
			if (spi_sck || !busy)
				stalled = 1'b0;
		end
		check_flag(stalled, "SCK kept running or busy fell with the receive queue full");
		check_value("bytes before stall", spi_pkg::FIFO_DEPTH + 1, resp_q.size());
		drain_rx(12);
		wait_idle();
		compare_tx();
		check_value("unread responses", 0, resp_q.size());
		resp_q.delete();
		end_test();

		begin_test("queue_limits");
		// Ninth write finds the queue full and is dropped
		for (int i = 0; i < spi_pkg::FIFO_DEPTH + 1; i++)
			write_byte(rand_byte(), i < spi_pkg::FIFO_DEPTH);
		check_value("tx_full", 1, tx_full);
		pulse_go();
		wait_idle();
		compare_tx();
		drain_rx(spi_pkg::FIFO_DEPTH);
		resp_q.delete();
		@(negedge clk);
		check_value("rx_empty", 1, rx_empty);
		rx_rd = 1'b1;
		@(negedge clk);
		rx_rd = 1'b0;
		check_value("rx_empty after empty read", 1, rx_empty);
		// Go with nothing queued
		pulse_go();
		repeat (4) begin
			@(negedge clk);
			check_value("busy", 0, busy);
			check_value("spi_cs_n", 1, spi_cs_n);
		end
		end_test();

		begin_test("framing");
		test_errs = frame_errs;
		check_flag(frame_checks > 0, "no SCK high time was ever measured");
		end_test();

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== hdl/byte_fifo.sv ====
module byte_fifo (
	input  logic                         clk,
	input  logic                         arst_n,

	// Write side
	input  logic                         wr,
	input  logic [spi_pkg::BYTE_W-1:0]   wr_data,
	output logic                         full,

	// Read side, head entry always visible
	input  logic                         rd,
	output logic [spi_pkg::BYTE_W-1:0]   rd_data,
	output logic                         empty
);

	////////////////////////////////////////////////////////////////////////////
	// Storage and pointers

	logic [spi_pkg::BYTE_W-1:0]   mem [spi_pkg::FIFO_DEPTH];
	logic [spi_pkg::FIFO_AW-1:0]  wr_ptr;
	logic [spi_pkg::FIFO_AW-1:0]  rd_ptr;
	// One extra bit so a full queue is distinct from an empty one
	logic [spi_pkg::FIFO_AW:0]    count;

	// Accepted operations, overflow and underflow are dropped
	logic do_wr;
	logic do_rd;

	assign full  = (count == (spi_pkg::FIFO_AW + 1)'(spi_pkg::FIFO_DEPTH));
	assign empty = (count == '0);

	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	// Head of queue
	assign rd_data = mem[rd_ptr];

	// Pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop together leave the count alone
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	// Data array
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

endmodule

// ==== hdl/spi_burst_ctrl.sv ====
module spi_burst_ctrl (
	input  logic                         clk,
	input  logic                         arst_n,

	// Host control
	input  logic                         go,
	output logic                         busy,
	input  logic [spi_pkg::HALF_W-1:0]   half_period,

	// Transmit queue read side
	output logic                         tx_rd,
	input  logic [spi_pkg::BYTE_W-1:0]   tx_head,
	input  logic                         tx_empty,

	// Receive queue write side
	output logic                         rx_wr,
	output logic [spi_pkg::BYTE_W-1:0]   rx_byte_out,
	input  logic                         rx_full,

	// Chip select and shifter handshake
	output logic                         cs_n,
	spi_byte_if.ctrl                     bus
);

	spi_pkg::ctrl_state_t         state;
	// Closing half period counter
	logic [spi_pkg::HALF_W-1:0]   hold_cnt;
	logic                         start_q;
	logic [spi_pkg::BYTE_W-1:0]   tx_byte_q;

	// Received byte goes into the queue this cycle
	logic push_shift;
	logic push_stall;

	assign push_shift = (state == spi_pkg::CS_SHIFT) && bus.done && !rx_full;
	assign push_stall = (state == spi_pkg::CS_STALL) && !rx_full;

	assign rx_wr       = push_shift || push_stall;
	// Shifter holds the received byte until the next start, also through a stall
	assign rx_byte_out = bus.rx_byte;

	// Pop the head while fetching it
	assign tx_rd = (state == spi_pkg::CS_SETUP);

	assign bus.start   = start_q;
	assign bus.tx_byte = tx_byte_q;

	////////////////////////////////////////////////////////////////////////////
	// Burst FSM

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= spi_pkg::CS_IDLE;
			hold_cnt <= '0;
			start_q  <= 1'b0;
			cs_n     <= 1'b1;
			busy     <= 1'b0;
		end else begin
			start_q <= 1'b0;

			case (state)
				spi_pkg::CS_IDLE: begin
					// Nothing to send means go is ignored
					if (go && !tx_empty) begin
						state <= spi_pkg::CS_SETUP;
						cs_n  <= 1'b0;
						busy  <= 1'b1;
					end
				end

				spi_pkg::CS_SETUP: begin
					start_q <= 1'b1;
					state   <= spi_pkg::CS_SHIFT;
				end

				spi_pkg::CS_SHIFT, spi_pkg::CS_STALL: begin
					if (state == spi_pkg::CS_SHIFT && bus.done && rx_full) begin
						state <= spi_pkg::CS_STALL;
					end else if (push_shift || push_stall) begin
						// Next byte, or wind down once the queue is drained
						if (tx_empty) begin
							state    <= spi_pkg::CS_HOLD;
							hold_cnt <= '0;
						end else begin
							state <= spi_pkg::CS_SETUP;
						end
					end
				end

				spi_pkg::CS_HOLD: begin
					if (hold_cnt >= half_period) begin
						state <= spi_pkg::CS_IDLE;
						cs_n  <= 1'b1;
						busy  <= 1'b0;
					end else begin
						hold_cnt <= hold_cnt + 1'b1;
					end
				end

				default: state <= spi_pkg::CS_IDLE;
			endcase
		end
	end

	// Byte register
	always_ff @(posedge clk) begin
		if (state == spi_pkg::CS_SETUP)
			tx_byte_q <= tx_head;
	end

endmodule

// ==== hdl/spi_byte_if.sv ====
interface spi_byte_if;

	// One-cycle start pulse, tx_byte valid with it
	logic                         start;
	logic [spi_pkg::BYTE_W-1:0]   tx_byte;

	// One-cycle done pulse, rx_byte valid with it and held until next start
	logic                         done;
	logic [spi_pkg::BYTE_W-1:0]   rx_byte;

	// Burst controller side
	modport ctrl (
		output start, tx_byte,
		input  done, rx_byte
	);

	// Transceiver side
	modport shifter (
		input  start, tx_byte,
		output done, rx_byte
	);

endinterface

// ==== hdl/spi_host_top.sv ====
module spi_host_top (
	input  logic                         clk,
	input  logic                         arst_n,

	// SCK half period minus one
	input  logic [spi_pkg::HALF_W-1:0]   half_period,

	// Transmit queue host side
	input  logic                         tx_wr,
	input  logic [spi_pkg::BYTE_W-1:0]   tx_data,
	output logic                         tx_full,

	// Burst control
	input  logic                         go,
	output logic                         busy,

	// Receive queue host side
	input  logic                         rx_rd,
	output logic [spi_pkg::BYTE_W-1:0]   rx_data,
	output logic                         rx_empty,

	// SPI pins
	output logic                         spi_sck,
	output logic                         spi_mosi,
	input  logic                         spi_miso,
	output logic                         spi_cs_n
);

	// Controller to queue wiring
	logic                         tx_rd;
	logic [spi_pkg::BYTE_W-1:0]   tx_head;
	logic                         tx_empty;
	logic                         rx_wr;
	logic [spi_pkg::BYTE_W-1:0]   rx_wr_data;
	logic                         rx_full;

	spi_byte_if i_byte_if ();

	////////////////////////////////////////////////////////////////////////////
	// Input side

	byte_fifo i_tx_fifo (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr      (tx_wr),
		.wr_data (tx_data),
		.full    (tx_full),
		.rd      (tx_rd),
		.rd_data (tx_head),
		.empty   (tx_empty)
	);

	////////////////////////////////////////////////////////////////////////////
	// Burst sequencing and SPI shifting

	spi_burst_ctrl i_burst_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.go          (go),
		.busy        (busy),
		.half_period (half_period),
		.tx_rd       (tx_rd),
		.tx_head     (tx_head),
		.tx_empty    (tx_empty),
		.rx_wr       (rx_wr),
		.rx_byte_out (rx_wr_data),
		.rx_full     (rx_full),
		.cs_n        (spi_cs_n),
		.bus         (i_byte_if.ctrl)
	);

	spi_shifter i_shifter (
		.clk         (clk),
		.arst_n      (arst_n),
		.half_period (half_period),
		.bus         (i_byte_if.shifter),
		.sck         (spi_sck),
		.mosi        (spi_mosi),
		.miso        (spi_miso)
	);

	////////////////////////////////////////////////////////////////////////////
	// Output side

	byte_fifo i_rx_fifo (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr      (rx_wr),
		.wr_data (rx_wr_data),
		.full    (rx_full),
		.rd      (rx_rd),
		.rd_data (rx_data),
		.empty   (rx_empty)
	);

endmodule

// ==== hdl/spi_pkg.sv ====
package spi_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data path sizing

	// Width of one SPI data byte
	localparam int BYTE_W = 8;

	// Entries in each byte queue
	localparam int FIFO_DEPTH = 8;

	// Queue pointer width, log2 of FIFO_DEPTH
	localparam int FIFO_AW = 3;

	////////////////////////////////////////////////////////////////////////////
	// SCK timing

	// Width of the half_period input
	// One SCK half period is half_period+1 clk cycles
	localparam int HALF_W = 8;

	////////////////////////////////////////////////////////////////////////////
	// Burst controller states

	typedef enum logic [2:0] {
		// Waiting for go
		CS_IDLE  = 3'd0,
		// Chip select low, next byte being fetched
		CS_SETUP = 3'd1,
		// Shifter running
		CS_SHIFT = 3'd2,
		// Receive queue full, byte parked
		CS_STALL = 3'd3,
		// Closing half period before chip select rises
		CS_HOLD  = 3'd4
	} ctrl_state_t;

endpackage

// ==== hdl/spi_shifter.sv ====
module spi_shifter (
	input  logic                         clk,
	input  logic                         arst_n,

	// SCK half period minus one, in clk cycles
	input  logic [spi_pkg::HALF_W-1:0]   half_period,

	// Byte handshake with the burst controller
	spi_byte_if.shifter                  bus,

	// SPI pins, mode 0
	output logic                         sck,
	output logic                         mosi,
	input  logic                         miso
);

	////////////////////////////////////////////////////////////////////////////
	// State

	// Byte in flight
	logic                         active;
	// Clock divider, counts through one half period
	logic [spi_pkg::HALF_W-1:0]   div_cnt;
	// Falling edges seen so far, 0 to 8
	logic [3:0]                   bit_cnt;
	logic                         done_q;

	// Remaining transmit bits, bit 7 already on MOSI
	logic [spi_pkg::BYTE_W-2:0]   tx_shreg;
	logic [spi_pkg::BYTE_W-1:0]   rx_shreg;

	// End of a half period
	logic tick;
	// Edge events at the end of the current half period
	logic rise_evt;
	logic fall_evt;
	logic last_evt;

	assign tick     = active && (div_cnt >= half_period);
	// Low phase with bits left becomes a rising edge
	assign rise_evt = tick && !sck && (bit_cnt != 4'd8);
	assign fall_evt = tick && sck;
	// Low phase after the eighth falling edge closes the byte
	assign last_evt = tick && !sck && (bit_cnt == 4'd8);

	// Received byte stays put until the next rising edge of the next byte
	assign bus.rx_byte = rx_shreg;
	assign bus.done    = done_q;

	////////////////////////////////////////////////////////////////////////////
	// Control and pins

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			active  <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			sck     <= 1'b0;
			mosi    <= 1'b0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;

			if (bus.start) begin
				// SCK idles low, MSB goes out right away
				active  <= 1'b1;
				div_cnt <= '0;
				bit_cnt <= '0;
				sck     <= 1'b0;
				mosi    <= bus.tx_byte[spi_pkg::BYTE_W-1];
			end else if (active) begin
				if (tick)
					div_cnt <= '0;
				else
					div_cnt <= div_cnt + 1'b1;

				if (rise_evt) begin
					sck <= 1'b1;
				end

				// Remote end has sampled, present the next bit
				if (fall_evt) begin
					sck     <= 1'b0;
					bit_cnt <= bit_cnt + 1'b1;
					mosi    <= tx_shreg[spi_pkg::BYTE_W-2];
				end

				if (last_evt) begin
					active <= 1'b0;
					done_q <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Shift registers

	always_ff @(posedge clk) begin
		if (bus.start)
			tx_shreg <= bus.tx_byte[spi_pkg::BYTE_W-2:0];
		else if (fall_evt)
			tx_shreg <= {tx_shreg[spi_pkg::BYTE_W-3:0], 1'b0};

		// MISO sampled just before SCK rises
		if (rise_evt)
			rx_shreg <= {rx_shreg[spi_pkg::BYTE_W-2:0], miso};
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SPI host testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -Wno-fatal --top-module spi_host_tb -f sim.f -o spi_host_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out="$(./obj_dir/spi_host_sim)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "TEST OK"; then
	exit 0
fi
exit 1

// ==== sim.f ====
hdl/spi_pkg.sv
hdl/spi_byte_if.sv
hdl/byte_fifo.sv
hdl/spi_shifter.sv
hdl/spi_burst_ctrl.sv
hdl/spi_host_top.sv
bench/spi_host_tb.sv
